// ==== filelist.f ====
uartPkg.sv
uartFifo.sv
uartTx.sv
uartRx.sv
uartRegs.sv
uartPeriph.sv
tbClock.sv
tbUart_assert.sv
tbUart.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass message in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbUart -f filelist.f -o simUart \
  && ./obj_dir/simUart 2>&1 | tee sim.log \
  && grep -q "=== PASS ===" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tbClock.sv ====
`default_nettype none
`timescale 1ns/1ns

module tbClock (
  output logic clkH,
  output logic rstN
);

  localparam int halfPeriodNs = 4;
  localparam int resetCycles  = 8;

  initial begin
    clkH = 1'b0;
    forever #(halfPeriodNs) clkH = ~clkH;
  end

  // Reset released on a rising edge after the hold time
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clkH);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tbUart.sv ====
`default_nettype none
`timescale 1ns/1ns

module tbUart import uartPkg::*; ();

  localparam logic [15:0] ctrlAddr = ioBase + {14'h0000, regCtrl};
  localparam logic [15:0] baudAddr = ioBase + {14'h0000, regBaud};
  localparam logic [15:0] dataAddr = ioBase + {14'h0000, regData};
  localparam logic [1:0]  sizeNone = 2'b00;
  localparam logic [1:0]  sizeByte = 2'b01;
  localparam logic [1:0]  sizeWord = 2'b10;
  localparam ioReq_t      idleReq  = '0;
  // Frames sent over all tests, each at most 11 bits of 41 cycles
  localparam int frameCount     = 27;
  localparam int maxFrameCycles = 11 * 41;
  localparam int watchdogNs     = frameCount * maxFrameCycles * 8 + 40000;

  wire    clkH;
  wire    rstN;
  wire    txLine;
  wire    sendBusy;
  wire    irq;
  ioReq_t req;
  ioRsp_t rsp;

  logic [15:0] lfsrState;
  int          cycleCount;
  logic        lastTx;
  int          edgeTimes[$];
  logic [7:0]  expQ[$];

  tbClock clockGen (.clkH(clkH), .rstN(rstN));

  // Serial line looped back from transmitter to receiver
  uartPeriph i_uartPeriph (
    .clkH(clkH), .rstN(rstN), .req(req), .rsp(rsp),
    .rxPin(txLine), .txPin(txLine), .sendBusy(sendBusy), .irq(irq)
  );

  // Start edges of frames, in clock cycles
  always @(negedge clkH) begin
    cycleCount = cycleCount + 1;
    if (lastTx && !txLine) begin
      edgeTimes.push_back(cycleCount);
    end
    lastTx = txLine;
  end

  function automatic logic [15:0] galoisStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic randomBits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = galoisStep(lfsrState);
      v = {v[14:0], lfsrState[0]};
    end
  endtask

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Control byte view of the status register
  function automatic logic [7:0] statusByte(input logic txEn, input logic rxEn,
      input logic twoStop, input logic busy, input logic canWr, input logic canRd);
    return {txEn, rxEn, 2'b00, twoStop, busy, canWr, canRd};
  endfunction

  task automatic busAccess(input logic [15:0] addr, input logic [1:0] wr,
      input logic [1:0] rd, input logic [15:0] data, output ioRsp_t result);
    @(posedge clkH);
    req <= '{addr: addr, wrSize: wr, rdSize: rd, wrData: data};
    @(negedge clkH);
    result = rsp;
    @(posedge clkH);
    req <= idleReq;
  endtask

  task automatic writeReg(input logic [15:0] addr, input logic [1:0] size,
                          input logic [15:0] data);
    ioRsp_t r;
    busAccess(addr, size, sizeNone, data, r);
    checkValue("rsp.ack", 16'd1, 16'(r.ack));
    checkValue("rsp.err", 16'd0, 16'(r.err));
  endtask

  task automatic readReg(input logic [15:0] addr, input logic [1:0] size,
                         output logic [15:0] data);
    ioRsp_t r;
    busAccess(addr, sizeNone, size, 16'h0000, r);
    checkValue("rsp.ack", 16'd1, 16'(r.ack));
    checkValue("rsp.err", 16'd0, 16'(r.err));
    data = r.rdData;
  endtask

  task automatic badAccess(input logic [15:0] addr, input logic [1:0] wr,
                           input logic [1:0] rd, input logic [15:0] data);
    ioRsp_t r;
    busAccess(addr, wr, rd, data, r);
    checkValue("rsp.ack", 16'd0, 16'(r.ack));
    checkValue("rsp.err", 16'd1, 16'(r.err));
  endtask

  task automatic readStatus(output logic [7:0] st);
    logic [15:0] w;
    readReg(ctrlAddr, sizeByte, w);
    st = w[7:0];
  endtask

  task automatic randomBaud(output logic [15:0] baud, output int div);
    logic [15:0] r;
    logic [15:0] f;
    randomBits(5, r);
    div = 16 + int'(r) % 25;
    randomBits(3, f);
    baud = {div[12:0], f[2:0]};
  endtask

  // Poll canRead, then pop one byte
  task automatic waitRxByte(output logic [7:0] b);
    logic [7:0]  st;
    logic [15:0] w;
    st = 8'h00;
    while (!st[0]) begin
      readStatus(st);
    end
    readReg(dataAddr, sizeByte, w);
    b = w[7:0];
  endtask

  task automatic waitTxIdle();
    do @(negedge clkH); while (sendBusy);
  endtask

  task automatic registerTest();
    logic [15:0] r;
    logic [15:0] baud;
    logic [15:0] got;
    logic [7:0]  ctrl;
    logic [7:0]  st;
    for (int i = 0; i < 4; i++) begin
      randomBits(8, r);
      ctrl = r[7:0] & 8'hCB;
      randomBits(16, baud);
      writeReg(ctrlAddr, sizeByte, {8'h00, ctrl});
      writeReg(baudAddr, sizeWord, baud);
      readStatus(st);
      checkValue("status", 16'(statusByte(ctrl[7], ctrl[6], ctrl[3], 0, 1, 0)), 16'(st));
      readReg(baudAddr, sizeWord, got);
      checkValue("baud", baud, got);
    end
    // Wrong sizes, unused offsets and mixed directions
    badAccess(ctrlAddr, sizeWord, sizeNone, 16'h00FF);
    badAccess(baudAddr, sizeByte, sizeNone, 16'h1234);
    badAccess(dataAddr, sizeWord, sizeNone, 16'h0055);
    badAccess(dataAddr, sizeNone, sizeWord, 16'h0000);
    badAccess(ioBase + 16'd3, sizeNone, sizeByte, 16'h0000);
    badAccess(ioBase + 16'h0100, sizeByte, sizeNone, 16'h00AA);
    badAccess(ctrlAddr, sizeByte, sizeByte, 16'h0000);
    badAccess(ctrlAddr, 2'b11, sizeNone, 16'h0000);
    readStatus(st);
    checkValue("status", 16'(statusByte(ctrl[7], ctrl[6], ctrl[3], 0, 1, 0)), 16'(st));
    readReg(baudAddr, sizeWord, got);
    checkValue("baud", baud, got);
    writeReg(ctrlAddr, sizeByte, 16'h0000);
  endtask

  task automatic loopbackTest();
    logic [15:0] baud;
    logic [15:0] r;
    logic [7:0]  got;
    int          div;
    for (int round = 0; round < 3; round++) begin
      randomBaud(baud, div);
      writeReg(baudAddr, sizeWord, baud);
      writeReg(ctrlAddr, sizeByte, {8'h00, 4'b1100, round[0], 3'b000});
      for (int k = 0; k < fifoDepth; k++) begin
        randomBits(8, r);
        writeReg(dataAddr, sizeByte, {8'h00, r[7:0]});
        expQ.push_back(r[7:0]);
      end
      while (expQ.size() > 0) begin
        waitRxByte(got);
        checkValue("rxByte", 16'(expQ.pop_front()), 16'(got));
      end
      waitTxIdle();
    end
  endtask

  task automatic fifoLimitTest();
    logic [15:0] r;
    logic [15:0] w;
    logic [7:0]  st;
    logic [7:0]  got;
    writeReg(ctrlAddr, sizeByte, 16'h0040);
    for (int k = 1; k <= 6; k++) begin
      randomBits(8, r);
      writeReg(dataAddr, sizeByte, {8'h00, r[7:0]});
      if (k <= fifoDepth) begin
        expQ.push_back(r[7:0]);
      end
      readStatus(st);
      checkValue("canWrite", 16'(k < fifoDepth), 16'(st[1]));
    end
    writeReg(ctrlAddr, sizeByte, 16'h00C0);
    while (expQ.size() > 0) begin
      waitRxByte(got);
      checkValue("rxByte", 16'(expQ.pop_front()), 16'(got));
    end
    waitTxIdle();
    readStatus(st);
    checkValue("canRead", 16'd0, 16'(st[0]));
    readReg(dataAddr, sizeByte, w);
    checkValue("emptyRead", 16'd0, w);
    writeReg(ctrlAddr, sizeByte, 16'h0000);
  endtask

  task automatic frameLengthTest();
    logic [15:0] baud;
    int          div;
    int          bits;
    int          spacing;
    int          bounded;
    for (int twoStop = 0; twoStop < 2; twoStop++) begin
      randomBaud(baud, div);
      writeReg(baudAddr, sizeWord, baud);
      writeReg(ctrlAddr, sizeByte, {8'h00, 4'b1000, twoStop[0], 3'b000});
      edgeTimes.delete();
      // All-ones bytes leave the start bit as the only falling edge
      repeat (3) writeReg(dataAddr, sizeByte, 16'h00FF);
      while (edgeTimes.size() < 3) @(posedge clkH);
      bits = (twoStop != 0) ? 11 : 10;
      for (int j = 1; j < 3; j++) begin
        spacing = edgeTimes[j] - edgeTimes[j - 1];
        bounded = spacing < bits * div ? bits * div :
                  (spacing > bits * (div + 1) ? bits * (div + 1) : spacing);
        checkValue("frameSpacing", 16'(bounded), 16'(spacing));
      end
      waitTxIdle();
    end
    writeReg(ctrlAddr, sizeByte, 16'h0000);
  endtask

  task automatic interruptTest();
    logic [15:0] r;
    logic [15:0] w;
    logic [7:0]  st;
    writeReg(ctrlAddr, sizeByte, 16'h00C1);
    @(negedge clkH);
    checkValue("irq", 16'd0, 16'(irq));
    randomBits(8, r);
    writeReg(dataAddr, sizeByte, {8'h00, r[7:0]});
    do @(negedge clkH); while (!irq);
    readStatus(st);
    checkValue("canRead", 16'd1, 16'(st[0]));
    readReg(dataAddr, sizeByte, w);
    checkValue("rxByte", {8'h00, r[7:0]}, w);
    @(negedge clkH);
    checkValue("irq", 16'd0, 16'(irq));
    waitTxIdle();
    // Transmit side interrupt with the transmitter held off
    writeReg(ctrlAddr, sizeByte, 16'h0002);
    @(negedge clkH);
    checkValue("irq", 16'd1, 16'(irq));
    for (int k = 1; k <= fifoDepth; k++) begin
      writeReg(dataAddr, sizeByte, 16'(k));
      @(negedge clkH);
      checkValue("irq", 16'(k < fifoDepth), 16'(irq));
    end
    writeReg(ctrlAddr, sizeByte, 16'h0082);
    do @(negedge clkH); while (!irq);
    readStatus(st);
    checkValue("canWrite", 16'd1, 16'(st[1]));
    waitTxIdle();
    writeReg(ctrlAddr, sizeByte, 16'h0000);
  endtask

  initial begin
    logic [7:0] st;
    req        = idleReq;
    lfsrState  = 16'd9;
    cycleCount = 0;
    lastTx     = 1'b1;
    @(posedge rstN);
    @(negedge clkH);
    checkValue("txPin", 16'd1, 16'(txLine));
    checkValue("sendBusy", 16'd0, 16'(sendBusy));
    checkValue("irq", 16'd0, 16'(irq));
    readStatus(st);
    checkValue("status", 16'(statusByte(0, 0, 0, 0, 1, 0)), 16'(st));
    registerTest();
    loopbackTest();
    fifoLimitTest();
    frameLengthTest();
    interruptTest();
    $display("=== PASS ===");
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("Watchdog expired before all tests finished");
    $display("=== FAIL ===");
    $fatal(1, "Simulation timed out");
  end

endmodule

`default_nettype wire

// ==== tbUart_assert.sv ====
`default_nettype none
`timescale 1ns/1ns

module tbUartAssert import uartPkg::*; (
  input  wire       clkH,
  input  wire       rstN,
  input  ioRsp_t    rsp,
  input  uartCfg_t  cfg,
  input  wire       txPin,
  input  wire       irq,
  input  wire       sendFull,
  input  wire       recvEmpty
);

  property ackErrExclusive;
    @(posedge clkH) disable iff (!rstN) !(rsp.ack && rsp.err);
  endproperty

  // Disabled transmitter keeps the line idle
  property idleWhenTxOff;
    @(posedge clkH) disable iff (!rstN) !cfg.txEn |-> txPin;
  endproperty

  property irqRule;
    @(posedge clkH) disable iff (!rstN)
      irq == ((!recvEmpty && cfg.irqEn[0]) || (!sendFull && cfg.irqEn[1]));
  endproperty

  assert property (ackErrExclusive) else $error("ack and err set together");
  assert property (idleWhenTxOff) else $error("txPin low while txEn is clear");
  assert property (irqRule) else $error("irq does not match FIFO flags and irqEn");

endmodule

bind uartPeriph tbUartAssert assertChecks (
  .clkH(clkH), .rstN(rstN), .rsp(rsp), .cfg(cfg), .txPin(txPin),
  .irq(irq), .sendFull(sendFull), .recvEmpty(recvEmpty)
);

`default_nettype wire

// ==== uartFifo.sv ====
`default_nettype none
`timescale 1ns/1ns

module uartFifo import uartPkg::*; (
  input  wire        clkH,
  input  wire        rstN,
  input  wire  [7:0] pushData,
  input  wire        push,
  output logic [7:0] popData,
  input  wire        pop,
  output logic       full,
  output logic       empty
);

  logic [7:0] mem [fifoDepth];
  logic [$clog2(fifoDepth)-1:0] wrPtr;
  logic [$clog2(fifoDepth)-1:0] rdPtr;
  logic [$clog2(fifoDepth):0]   count;
  logic wrEn;
  logic rdEn;

  // Guard against a push into a full buffer or a pop from an empty one
  assign wrEn = push && !full;
  assign rdEn = pop && !empty;

  assign full  = (count == fifoDepth);
  assign empty = (count == '0);

  // Head of the queue, visible before it is popped
  assign popData = mem[rdPtr];

  always_ff @(posedge clkH) begin
    if (wrEn) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clkH or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (rdEn) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({wrEn, rdEn})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uartPeriph.sv ====
`default_nettype none
`timescale 1ns/1ns

module uartPeriph import uartPkg::*; (
  input  wire     clkH,
  input  wire     rstN,
  input  ioReq_t  req,
  output ioRsp_t  rsp,
  input  wire     rxPin,
  output logic    txPin,
  output logic    sendBusy,
  output logic    irq
);

  uartCfg_t   cfg;
  logic       sendPush;
  logic       sendFull;
  logic       sendEmpty;
  logic       sendPop;
  logic [7:0] sendData;
  logic       recvPush;
  logic       recvPop;
  logic       recvEmpty;
  logic [7:0] recvByte;
  logic [7:0] recvData;

  uartRegs regs (
    .clkH(clkH), .rstN(rstN),
    .req(req), .rsp(rsp), .cfg(cfg),
    .sendPush(sendPush), .sendFull(sendFull),
    .recvPop(recvPop), .recvData(recvData), .recvEmpty(recvEmpty),
    .sendBusy(sendBusy), .irq(irq)
  );

  // Host writes go straight into the send queue
  uartFifo sendFifo (
    .clkH(clkH), .rstN(rstN),
    .pushData(req.wrData[7:0]), .push(sendPush),
    .popData(sendData), .pop(sendPop),
    .full(sendFull), .empty(sendEmpty)
  );

  // Receive queue, overflow is dropped inside the FIFO
  uartFifo recvFifo (
    .clkH(clkH), .rstN(rstN),
    .pushData(recvByte), .push(recvPush),
    .popData(recvData), .pop(recvPop),
    .full(), .empty(recvEmpty)
  );

  uartTx tx (
    .clkH(clkH), .rstN(rstN), .cfg(cfg),
    .sendData(sendData), .sendEmpty(sendEmpty), .sendPop(sendPop),
    .txPin(txPin), .sendBusy(sendBusy)
  );

  uartRx rx (
    .clkH(clkH), .rstN(rstN), .cfg(cfg),
    .rxPin(rxPin), .recvData(recvByte), .recvPush(recvPush)
  );

endmodule

`default_nettype wire

// ==== uartPkg.sv ====
`default_nettype none

package uartPkg;

  // Bus request, one-hot sizes: bit 0 byte, bit 1 word
  typedef struct packed {
    logic [15:0] addr;
    logic [1:0]  wrSize;
    logic [1:0]  rdSize;
    logic [15:0] wrData;
  } ioReq_t;

  typedef struct packed {
    logic [15:0] rdData;
    logic        ack;
    logic        err;
  } ioRsp_t;

  // Baud word as seen by the host, or split into cycles per bit and fraction
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [12:0] divisor;
      logic [2:0]  frac;
    } fields;
  } baudWord_t;

  typedef struct packed {
    logic       txEn;
    logic       rxEn;
    logic       twoStop;
    logic [1:0] irqEn;
    baudWord_t  baud;
  } uartCfg_t;

  // Register map
  localparam logic [15:0] ioBase  = 16'h0000;
  localparam logic [1:0]  regCtrl = 2'd0;
  localparam logic [1:0]  regBaud = 2'd1;
  localparam logic [1:0]  regData = 2'd2;

  localparam int fifoDepth = 4;

  // One pattern per fraction value; a 0 bit shortens that frame bit by one cycle
  localparam logic [0:7][7:0] baudFracTable = {
    8'b00001000,
    8'b10001000,
    8'b10100100,
    8'b10101010,
    8'b10110110,
    8'b11101110,
    8'b11101111,
    8'b11111111
  };

  // Counter reload for frame bit idx, the bit then lasts reload plus one cycles
  function automatic logic [12:0] bitReload(input baudWord_t baud, input logic [3:0] idx);
    logic shortBit;
    shortBit = (idx < 4'd8) && !baudFracTable[baud.fields.frac][idx[2:0]];
    return baud.fields.divisor - {12'h000, shortBit};
  endfunction

endpackage

`default_nettype wire

// ==== uartRegs.sv ====
`default_nettype none
`timescale 1ns/1ns

module uartRegs import uartPkg::*; (
  input  wire        clkH,
  input  wire        rstN,
  input  ioReq_t     req,
  output ioRsp_t     rsp,
  output uartCfg_t   cfg,
  output logic       sendPush,
  input  wire        sendFull,
  output logic       recvPop,
  input  wire  [7:0] recvData,
  input  wire        recvEmpty,
  input  wire        sendBusy,
  output logic       irq
);

  uartCfg_t   cfgQ;
  logic       isCtrl;
  logic       isBaud;
  logic       isData;
  logic       byteWr;
  logic       wordWr;
  logic       byteRd;
  logic       wordRd;
  logic       wrCtrl;
  logic       wrBaud;
  logic       wrData;
  logic       rdCtrl;
  logic       rdBaud;
  logic       rdData;
  logic       canWrite;
  logic       canRead;
  logic [15:0] rdMux;

  assign isCtrl = (req.addr == ioBase + {14'h0000, regCtrl});
  assign isBaud = (req.addr == ioBase + {14'h0000, regBaud});
  assign isData = (req.addr == ioBase + {14'h0000, regData});

  // Exactly one direction with exactly one size
  assign byteWr = (req.wrSize == 2'b01) && (req.rdSize == 2'b00);
  assign wordWr = (req.wrSize == 2'b10) && (req.rdSize == 2'b00);
  assign byteRd = (req.rdSize == 2'b01) && (req.wrSize == 2'b00);
  assign wordRd = (req.rdSize == 2'b10) && (req.wrSize == 2'b00);

  assign wrCtrl = isCtrl && byteWr;
  assign rdCtrl = isCtrl && byteRd;
  assign wrBaud = isBaud && wordWr;
  assign rdBaud = isBaud && wordRd;
  assign wrData = isData && byteWr;
  assign rdData = isData && byteRd;

  assign rsp.ack = wrCtrl || rdCtrl || wrBaud || rdBaud || wrData || rdData;
  assign rsp.err = ((|req.wrSize) || (|req.rdSize)) && !rsp.ack;

  // Control byte layout: [7] txEn [6] rxEn [3] twoStop [1:0] irqEn
  always_ff @(posedge clkH or negedge rstN) begin
    if (!rstN) begin
      cfgQ <= '0;
    end else begin
      if (wrCtrl) begin
        cfgQ.txEn    <= req.wrData[7];
        cfgQ.rxEn    <= req.wrData[6];
        cfgQ.twoStop <= req.wrData[3];
        cfgQ.irqEn   <= req.wrData[1:0];
      end
      if (wrBaud) begin
        cfgQ.baud.raw <= req.wrData;
      end
    end
  end

  assign cfg = cfgQ;

  assign canWrite = !sendFull;
  assign canRead  = !recvEmpty;

  // Full FIFO drops the byte, empty FIFO reads as zero
  assign sendPush = wrData && canWrite;
  assign recvPop  = rdData && canRead;

  // Status keeps the flags aligned with their irqEn bits
  always_comb begin
    rdMux = 16'h0000;
    if (rdCtrl) begin
      rdMux = {8'h00, cfgQ.txEn, cfgQ.rxEn, 2'b00, cfgQ.twoStop, sendBusy, canWrite, canRead};
    end else if (rdBaud) begin
      rdMux = cfgQ.baud.raw;
    end else if (rdData && canRead) begin
      rdMux = {8'h00, recvData};
    end
  end

  assign rsp.rdData = rdMux;

  assign irq = (canRead && cfgQ.irqEn[0]) || (canWrite && cfgQ.irqEn[1]);

endmodule

`default_nettype wire

// ==== uartRx.sv ====
`default_nettype none
`timescale 1ns/1ns

module uartRx import uartPkg::*; (
  input  wire        clkH,
  input  wire        rstN,
  input  uartCfg_t   cfg,
  input  wire        rxPin,
  output logic [7:0] recvData,
  output logic       recvPush
);

  // Two synchronizer stages plus one more for edge detection
  logic [2:0]  rxSync;
  logic        line;
  logic        fallEdge;
  logic        inStart;
  logic        inData;
  logic [3:0]  bitIdx;
  logic [12:0] baudCnt;
  logic [7:0]  shiftReg;
  logic        sampleNow;

  assign line     = rxSync[1];
  assign fallEdge = rxSync[2] && !rxSync[1];

  assign sampleNow = inData && (baudCnt == 13'd0);

  always_ff @(posedge clkH or negedge rstN) begin
    if (!rstN) begin
      rxSync  <= 3'b111;
      inStart <= 1'b0;
      inData  <= 1'b0;
      bitIdx  <= 4'd0;
      baudCnt <= 13'd0;
    end else begin
      rxSync <= {rxSync[1:0], rxPin};
      if (!cfg.rxEn) begin
        // Disable drops any frame in progress
        inStart <= 1'b0;
        inData  <= 1'b0;
      end else if (inStart) begin
        if (baudCnt != 13'd0) begin
          baudCnt <= baudCnt - 13'd1;
        end else begin
          inStart <= 1'b0;
          // Middle of start bit, a high line here was only a glitch
          if (!line) begin
            inData  <= 1'b1;
            bitIdx  <= 4'd1;
            baudCnt <= bitReload(cfg.baud, 4'd1);
          end
        end
      end else if (inData) begin
        if (baudCnt != 13'd0) begin
          baudCnt <= baudCnt - 13'd1;
        end else if (bitIdx == 4'd8) begin
          inData <= 1'b0;
        end else begin
          bitIdx  <= bitIdx + 4'd1;
          baudCnt <= bitReload(cfg.baud, bitIdx + 4'd1);
        end
      end else if (fallEdge) begin
        inStart <= 1'b1;
        baudCnt <= {1'b0, cfg.baud.fields.divisor[12:1]};
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clkH) begin
    if (sampleNow) begin
      shiftReg <= {line, shiftReg[7:1]};
    end
  end

  // Byte is complete in the cycle that samples the last data bit
  assign recvData = {line, shiftReg[7:1]};
  assign recvPush = sampleNow && (bitIdx == 4'd8) && cfg.rxEn;

endmodule

`default_nettype wire

// ==== uartTx.sv ====
`default_nettype none
`timescale 1ns/1ns

module uartTx import uartPkg::*; (
  input  wire        clkH,
  input  wire        rstN,
  input  uartCfg_t   cfg,
  input  wire  [7:0] sendData,
  input  wire        sendEmpty,
  output logic       sendPop,
  output logic       txPin,
  output logic       sendBusy
);

  logic        busy;
  logic [3:0]  bitIdx;
  logic [3:0]  lastIdx;
  logic [12:0] baudCnt;
  logic [10:0] shiftReg;
  logic        frameEnd;
  logic        load;

  // Frame bit 0 is the start bit, 1..8 data, then one or two stop bits
  assign lastIdx = cfg.twoStop ? 4'd10 : 4'd9;

  assign frameEnd = busy && (baudCnt == 13'd0) && (bitIdx == lastIdx);

  // A new byte may follow directly in the last cycle of the previous stop bit
  assign load = (!busy || frameEnd) && cfg.txEn && !sendEmpty;

  always_ff @(posedge clkH or negedge rstN) begin
    if (!rstN) begin
      busy     <= 1'b0;
      bitIdx   <= 4'd0;
      baudCnt  <= 13'd0;
      shiftReg <= '1;
    end else if (load) begin
      busy     <= 1'b1;
      bitIdx   <= 4'd0;
      baudCnt  <= bitReload(cfg.baud, 4'd0);
      // Stop bits, data LSB first, start bit
      shiftReg <= {2'b11, sendData, 1'b0};
    end else if (frameEnd) begin
      busy     <= 1'b0;
      shiftReg <= '1;
    end else if (busy) begin
      if (baudCnt != 13'd0) begin
        baudCnt <= baudCnt - 13'd1;
      end else begin
        bitIdx   <= bitIdx + 4'd1;
        baudCnt  <= bitReload(cfg.baud, bitIdx + 4'd1);
        shiftReg <= {1'b1, shiftReg[10:1]};
      end
    end
  end

  assign sendPop  = load;
  assign sendBusy = busy;

  // Line stays idle high while the transmitter is disabled
  assign txPin = cfg.txEn ? shiftReg[0] : 1'b1;

endmodule

`default_nettype wire
